// File: verilog.f
+incdir+source
+incdir+bench
source/exec_pkg.sv
source/operand_bypass.sv
source/exec_alu.sv
source/exec_mul.sv
source/branch_resolve.sv
source/lsu_align.sv
source/exec_stage.sv
bench/exec_tb.sv

// File: Makefile
TOP := exec_tb

sim:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: bench/exec_ref.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// nearest stage first, r0 never forwarded
function automatic logic [31:0] pick_operand(input logic [4:0] raddr, input logic [31:0] reg_value,
                                              input fwd_t f1, input fwd_t f2);
    if (raddr != 5'd0 && f1.we && f1.dest == raddr) begin
        return f1.data;
    end
    if (raddr != 5'd0 && f2.we && f2.dest == raddr) begin
        return f2.data;
    end
    return reg_value;
endfunction

function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        alu_add:  return a + b;
        alu_sub:  return a - b;
        alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        alu_and:  return a & b;
        alu_or:   return a | b;
        alu_nor:  return ~(a | b);
        alu_xor:  return a ^ b;
        alu_sll:  return a << sh;
        alu_srl:  return a >> sh;
        alu_sra:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);  // fill sign
        alu_lui:  return b;
        default:  return 32'h0;
    endcase
endfunction

function automatic logic [31:0] mul_model(input logic [31:0] a, input logic [31:0] b,
                                           input logic high, input logic uns);
    logic [63:0] p;
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (uns) begin
        p = {32'h0, a} * {32'h0, b};
    end else begin
        p = sa * sb;
    end
    return high ? p[63:32] : p[31:0];
endfunction

function automatic redirect_t resolve_branch(input br_kind_e kind, input logic pred_taken,
                                              input logic [31:0] a, input logic [31:0] b,
                                              input logic [31:0] pc, input logic [31:0] rj,
                                              input logic [31:0] imm);
    redirect_t r;
    logic taken;
    case (kind)
        br_beq:      taken = (a == b);
        br_bne:      taken = (a != b);
        br_blt:      taken = ($signed(a) < $signed(b));
        br_bge:      taken = ($signed(a) >= $signed(b));
        br_bltu:     taken = (a < b);
        br_bgeu:     taken = (a >= b);
        br_jump:     taken = 1'b1;
        br_jump_reg: taken = 1'b1;
        default:     taken = 1'b0;
    endcase
    if (!taken) begin
        r.target = pc + 32'd4;
    end else if (kind == br_jump_reg) begin
        r.target = rj + imm;
    end else begin
        r.target = pc + imm;
    end
    r.flush = (taken != pred_taken);
    return r;
endfunction

function automatic dmem_req_t align_store(input logic we, input logic rd, input mem_size_e size,
                                           input logic [31:0] base, input logic [31:0] offset,
                                           input logic [31:0] data);
    dmem_req_t q;
    logic [3:0] lanes;
    q.addr = base + offset;
    case (size)
        mem_byte: begin
            case (q.addr[1:0])
                2'd0: lanes = 4'b0001;
                2'd1: lanes = 4'b0010;
                2'd2: lanes = 4'b0100;
                default: lanes = 4'b1000;
            endcase
            q.wdata = {data[7:0], data[7:0], data[7:0], data[7:0]};
        end
        mem_half: begin
            lanes = q.addr[1] ? 4'b1100 : 4'b0011;
            q.wdata = {data[15:0], data[15:0]};
        end
        default: begin
            lanes = 4'b1111;
            q.wdata = data;
        end
    endcase
    q.we = we;
    q.rd = rd;
    q.be = we ? lanes : 4'b0000;
    return q;
endfunction

`endif

// File: bench/exec_tb.sv
`default_nettype none
`include "exec_cfg.svh"

module exec_tb import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INSTR    = 400;
    localparam int MAX_CYCLES = 5000;

    logic       clk;
    logic       reset;
    logic       ds_valid;
    dec_bus_t   ds_bus;
    logic       es_allowin;
    logic       ws_allowin;
    logic       es_valid_out;
    wb_bus_t    es_bus;
    fwd_t       fwd1;
    fwd_t       fwd2;
    fwd_t       fwd_out;
    redirect_t  redirect;
    dmem_req_t  dmem_req;
    dmem_resp_t dmem_resp;

    logic [31:0] rng_state = 32'd1759;
    dec_bus_t    pending[$];  // accepted, not yet retired
    int          sent_count = 0;
    int          done_count = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    `include "exec_ref.svh"

    exec_stage i_dut (
        .clk          (clk),
        .reset        (reset),
        .ds_valid     (ds_valid),
        .ds_bus       (ds_bus),
        .es_allowin   (es_allowin),
        .ws_allowin   (ws_allowin),
        .es_valid_out (es_valid_out),
        .es_bus       (es_bus),
        .fwd1         (fwd1),
        .fwd2         (fwd2),
        .fwd_out      (fwd_out),
        .redirect     (redirect),
        .dmem_req     (dmem_req),
        .dmem_resp    (dmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic fwd_t random_fwd();
        fwd_t f;
        logic [31:0] r;
        r = rand32();
        f.we = r[0] | r[1];
        f.dest = {3'b000, r[3:2]};  // small range so matches happen
        f.data = rand32();
        return f;
    endfunction

    function automatic dec_bus_t random_instr();
        dec_bus_t d;
        logic [31:0] r;
        logic [31:0] p;
        logic [3:0] op_sel;
        logic [3:0] kind_sel;
        r = rand32();
        p = rand32();
        op_sel = r[3:0];
        if (op_sel > 4'd11) begin
            op_sel = op_sel - 4'd4;
        end
        kind_sel = r[7:4];
        if (kind_sel > 4'd8) begin
            kind_sel = kind_sel - 4'd7;
        end
        d.alu_op       = alu_op_e'(op_sel);
        d.br_kind      = br_kind_e'(kind_sel);
        d.pred_taken   = r[8];
        d.src1_is_pc   = r[9] & r[10];
        d.src2_is_imm  = r[11];
        d.src2_is_4    = r[12] & r[13];
        d.gr_we        = r[14];
        d.dest         = {3'b000, r[16:15]};
        d.mem_we       = r[17] & r[18];
        d.mem_rd       = r[19] & r[20];
        d.mem_size     = (r[22:21] == 2'd3) ? mem_word : mem_size_e'(r[22:21]);
        d.use_mul      = r[23];
        d.mul_high     = r[24];
        d.mul_unsigned = r[25];
        d.raddr1       = {3'b000, r[27:26]};
        d.raddr2       = {3'b000, r[29:28]};
        d.rj_value     = rand32();
        d.rkd_value    = r[30] ? d.rj_value : rand32();  // equal operands for beq and friends
        d.imm          = r[31] ? d.rj_value : rand32();
        d.pc           = {p[31:2], 2'b00};
        return d;
    endfunction

    task automatic check_value(input string what, input logic [69:0] got,
                               input logic [69:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = rand32();
        ds_valid         = (sent_count < N_INSTR) && (r[1:0] != 2'b00);
        ws_allowin       = (r[3:2] != 2'b00);
        ds_bus           = random_instr();
        fwd1             = random_fwd();
        fwd2             = random_fwd();
        dmem_resp.ready  = r[4] | r[5];
        dmem_resp.rvalid = r[6] | r[7];
        dmem_resp.rdata  = rand32();
    endtask

    task automatic check_slot(input dec_bus_t d);
        logic [31:0] rj;
        logic [31:0] rkd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        wb_bus_t     exp_wb;
        fwd_t        exp_fwd;
        rj  = pick_operand(d.raddr1, d.rj_value, fwd1, fwd2);
        rkd = pick_operand(d.raddr2, d.rkd_value, fwd1, fwd2);
        a   = d.src1_is_pc ? d.pc : rj;
        b   = d.src2_is_imm ? d.imm : (d.src2_is_4 ? 32'd4 : rkd);
        if (d.mem_rd) begin
            result = (dmem_resp.ready && dmem_resp.rvalid) ? dmem_resp.rdata : 32'h0;
        end else if (d.use_mul) begin
            result = mul_model(a, b, d.mul_high, d.mul_unsigned);
        end else begin
            result = alu_model(d.alu_op, a, b);
        end
        check_value("redirect", 70'(redirect),
                    70'(resolve_branch(d.br_kind, d.pred_taken, a, b, d.pc, rj, d.imm)));
        check_value("dmem_req", 70'(dmem_req),
                    70'(align_store(d.mem_we, d.mem_rd, d.mem_size, rj, d.imm, rkd)));
        exp_fwd.we   = d.gr_we;
        exp_fwd.dest = d.dest;
        exp_fwd.data = result;
        check_value("fwd_out", 70'(fwd_out), 70'(exp_fwd));
        check_value("es_bus pc", 70'(es_bus.pc), 70'(d.pc));  // head holds while stalled
        if (ws_allowin) begin
            exp_wb.gr_we  = d.gr_we;
            exp_wb.dest   = d.dest;
            exp_wb.result = result;
            exp_wb.pc     = d.pc;
            check_value("es_bus", 70'(es_bus), 70'(exp_wb));
        end
    endtask

    task automatic check_cycle();
        logic accept;
        accept = ds_valid && es_allowin;
        check_value("es_allowin", 70'(es_allowin), 70'(pending.size() == 0 || ws_allowin));
        if (es_valid_out) begin
            assert (pending.size() != 0) else begin
                errors++;
                $display("stage shows a valid instruction at %0t that was never accepted",
                         $time);
            end
            if (pending.size() != 0) begin
                check_slot(pending[0]);
                if (ws_allowin) begin
                    void'(pending.pop_front());
                    done_count++;
                end
            end
        end else begin
            check_value("idle outputs", 70'({redirect.flush, dmem_req.we, dmem_req.rd,
                        dmem_req.be, fwd_out.we}), 70'(0));
            assert (pending.size() == 0) else begin
                errors++;
                $display("an accepted instruction was dropped before %0t", $time);
                pending.delete();
            end
        end
        if (accept) begin
            pending.push_back(ds_bus);
            sent_count++;
        end
    endtask

    initial begin
        reset      = 1'b1;
        ds_valid   = 1'b0;
        ds_bus     = '0;
        ws_allowin = 1'b0;
        fwd1       = '0;
        fwd2       = '0;
        dmem_resp  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("outputs after reset", 70'({es_valid_out, redirect.flush, dmem_req.we,
                    dmem_req.rd, dmem_req.be, fwd_out.we, !es_allowin}), 70'(0));
        while ((sent_count < N_INSTR || pending.size() != 0) && cycles < MAX_CYCLES) begin
            drive_inputs();
            @(posedge clk);
            cycles++;
            check_cycle();
            @(negedge clk);
        end
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout: the stage did not retire %0d instructions in %0d cycles",
                     N_INSTR, MAX_CYCLES);
        end
        check_value("retired count", 70'(done_count), 70'(sent_count));
        $display("checks %0d, errors %0d, instructions %0d", checks, errors, done_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/exec_stage.sv
`default_nettype none
`include "exec_cfg.svh"

module exec_stage import exec_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       ds_valid,
    input  wire dec_bus_t   ds_bus,
    output logic            es_allowin,
    input  wire logic       ws_allowin,
    output logic            es_valid_out,
    output wb_bus_t         es_bus,
    input  wire fwd_t       fwd1,
    input  wire fwd_t       fwd2,
    output fwd_t            fwd_out,
    output redirect_t       redirect,
    output dmem_req_t       dmem_req,
    input  wire dmem_resp_t dmem_resp
);

    logic                  es_valid;
    dec_bus_t              bus_r;
    logic [`EXEC_XLEN-1:0] rj_value;
    logic [`EXEC_XLEN-1:0] rkd_value;
    logic [`EXEC_XLEN-1:0] src1;
    logic [`EXEC_XLEN-1:0] src2;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] mul_result;
    logic [`EXEC_XLEN-1:0] mem_result;
    logic [`EXEC_XLEN-1:0] final_result;
    logic                  zero;
    logic                  less_signed;
    logic                  less_unsigned;

    // single-entry slot, ready_go is always true
    assign es_allowin   = !es_valid || ws_allowin;
    assign es_valid_out = es_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            bus_r <= ds_bus;
        end
    end

    operand_bypass i_bypass_rj (
        .raddr     (bus_r.raddr1),
        .reg_value (bus_r.rj_value),
        .fwd1      (fwd1),
        .fwd2      (fwd2),
        .value     (rj_value)
    );

    operand_bypass i_bypass_rkd (
        .raddr     (bus_r.raddr2),
        .reg_value (bus_r.rkd_value),
        .fwd1      (fwd1),
        .fwd2      (fwd2),
        .value     (rkd_value)
    );

    assign src1 = bus_r.src1_is_pc ? bus_r.pc : rj_value;
    assign src2 = bus_r.src2_is_imm ? bus_r.imm :
                  bus_r.src2_is_4   ? `EXEC_XLEN'(`EXEC_PC_STEP) : rkd_value;  // link address

    exec_alu i_alu (
        .op            (bus_r.alu_op),
        .src1          (src1),
        .src2          (src2),
        .result        (alu_result),
        .zero          (zero),
        .less_signed   (less_signed),
        .less_unsigned (less_unsigned)
    );

    exec_mul i_mul (
        .src1        (src1),
        .src2        (src2),
        .high        (bus_r.mul_high),
        .is_unsigned (bus_r.mul_unsigned),
        .result      (mul_result)
    );

    branch_resolve i_branch (
        .valid         (es_valid),
        .kind          (bus_r.br_kind),
        .pred_taken    (bus_r.pred_taken),
        .zero          (zero),
        .less_signed   (less_signed),
        .less_unsigned (less_unsigned),
        .pc            (bus_r.pc),
        .rj            (rj_value),
        .imm           (bus_r.imm),
        .redirect      (redirect)
    );

    lsu_align i_lsu (
        .valid      (es_valid),
        .mem_we     (bus_r.mem_we),
        .mem_rd     (bus_r.mem_rd),
        .size       (bus_r.mem_size),
        .base       (rj_value),
        .offset     (bus_r.imm),
        .store_data (rkd_value),
        .req        (dmem_req)
    );

    assign mem_result = (dmem_resp.ready && dmem_resp.rvalid) ? dmem_resp.rdata : '0;

    // load, then product, then alu
    assign final_result = bus_r.mem_rd  ? mem_result :
                          bus_r.use_mul ? mul_result : alu_result;

    assign es_bus.gr_we  = bus_r.gr_we;
    assign es_bus.dest   = bus_r.dest;
    assign es_bus.result = final_result;
    assign es_bus.pc     = bus_r.pc;

    assign fwd_out.we   = es_valid && bus_r.gr_we;
    assign fwd_out.dest = bus_r.dest;
    assign fwd_out.data = final_result;

endmodule

`default_nettype wire

// File: source/lsu_align.sv
`default_nettype none
`include "exec_cfg.svh"

module lsu_align import exec_pkg::*; (
    input  wire logic                  valid,
    input  wire logic                  mem_we,
    input  wire logic                  mem_rd,
    input  wire mem_size_e             size,
    input  wire logic [`EXEC_XLEN-1:0] base,
    input  wire logic [`EXEC_XLEN-1:0] offset,
    input  wire logic [`EXEC_XLEN-1:0] store_data,
    output dmem_req_t                  req
);

    logic [`EXEC_XLEN-1:0]  addr;
    logic [`EXEC_LANES-1:0] lane_mask;
    logic [`EXEC_XLEN-1:0]  lane_data;
    logic                   store;

    assign addr  = base + offset;
    assign store = valid && mem_we;

    always_comb begin
        case (size)
            mem_byte: begin
                lane_mask = `EXEC_LANES'(1) << addr[1:0];
                lane_data = {4{store_data[7:0]}};
            end
            mem_half: begin
                lane_mask = addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{store_data[15:0]}};
            end
            default: begin
                lane_mask = '1;  // full word
                lane_data = store_data;
            end
        endcase
    end

    assign req.we    = store;
    assign req.rd    = valid && mem_rd;
    assign req.be    = store ? lane_mask : '0;
    assign req.addr  = addr;
    assign req.wdata = lane_data;

endmodule

`default_nettype wire

// File: source/branch_resolve.sv
`default_nettype none
`include "exec_cfg.svh"

module branch_resolve import exec_pkg::*; (
    input  wire logic                  valid,
    input  wire br_kind_e              kind,
    input  wire logic                  pred_taken,
    input  wire logic                  zero,
    input  wire logic                  less_signed,
    input  wire logic                  less_unsigned,
    input  wire logic [`EXEC_XLEN-1:0] pc,
    input  wire logic [`EXEC_XLEN-1:0] rj,
    input  wire logic [`EXEC_XLEN-1:0] imm,
    output redirect_t                  redirect
);

    logic                  taken;
    logic [`EXEC_XLEN-1:0] jump_target;

    always_comb begin
        case (kind)
            br_beq:      taken = zero;
            br_bne:      taken = !zero;
            br_blt:      taken = less_signed;
            br_bge:      taken = !less_signed;
            br_bltu:     taken = less_unsigned;
            br_bgeu:     taken = !less_unsigned;
            br_jump:     taken = 1'b1;
            br_jump_reg: taken = 1'b1;
            default:     taken = 1'b0;  // br_none
        endcase
    end

    assign jump_target = (kind == br_jump_reg) ? (rj + imm) : (pc + imm);

    assign redirect.target = taken ? jump_target : (pc + `EXEC_XLEN'(`EXEC_PC_STEP));
    assign redirect.flush  = valid && (taken != pred_taken);  // mispredict

endmodule

`default_nettype wire

// File: source/exec_mul.sv
`default_nettype none
`include "exec_cfg.svh"

module exec_mul (
    input  wire logic [`EXEC_XLEN-1:0] src1,
    input  wire logic [`EXEC_XLEN-1:0] src2,
    input  wire logic                  high,
    input  wire logic                  is_unsigned,
    output logic [`EXEC_XLEN-1:0]      result
);

    logic signed [`EXEC_XLEN:0]       op_a;
    logic signed [`EXEC_XLEN:0]       op_b;
    logic signed [2*`EXEC_XLEN+1:0]   product;

    // one extra bit lets a signed multiply cover both cases
    assign op_a = {(is_unsigned ? 1'b0 : src1[`EXEC_XLEN-1]), src1};
    assign op_b = {(is_unsigned ? 1'b0 : src2[`EXEC_XLEN-1]), src2};

    assign product = op_a * op_b;

    assign result = high ? product[2*`EXEC_XLEN-1:`EXEC_XLEN]
                         : product[`EXEC_XLEN-1:0];

endmodule

`default_nettype wire

// File: source/exec_alu.sv
`default_nettype none
`include "exec_cfg.svh"

module exec_alu import exec_pkg::*; (
    input  wire alu_op_e               op,
    input  wire logic [`EXEC_XLEN-1:0] src1,
    input  wire logic [`EXEC_XLEN-1:0] src2,
    output logic [`EXEC_XLEN-1:0]      result,
    output logic                       zero,
    output logic                       less_signed,
    output logic                       less_unsigned
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    // compare flags, also used by branch_resolve
    assign zero          = (src1 == src2);
    assign less_signed   = ($signed(src1) < $signed(src2));
    assign less_unsigned = (src1 < src2);

    always_comb begin
        case (op)
            alu_add: begin
                result = src1 + src2;
            end
            alu_sub: begin
                result = src1 - src2;
            end
            alu_slt: begin
                result = {{(`EXEC_XLEN-1){1'b0}}, less_signed};
            end
            alu_sltu: begin
                result = {{(`EXEC_XLEN-1){1'b0}}, less_unsigned};
            end
            alu_and: begin
                result = src1 & src2;
            end
            alu_or: begin
                result = src1 | src2;
            end
            alu_nor: begin
                result = ~(src1 | src2);
            end
            alu_xor: begin
                result = src1 ^ src2;
            end
            alu_sll: begin
                result = src1 << shamt;
            end
            alu_srl: begin
                result = src1 >> shamt;
            end
            alu_sra: begin
                result = $signed(src1) >>> shamt;
            end
            alu_lui: begin
                result = src2;  // upper immediate prepared by decode
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/operand_bypass.sv
`default_nettype none
`include "exec_cfg.svh"

module operand_bypass import exec_pkg::*; (
    input  wire logic [`EXEC_RAW-1:0]  raddr,
    input  wire logic [`EXEC_XLEN-1:0] reg_value,
    input  wire fwd_t                  fwd1,
    input  wire fwd_t                  fwd2,
    output logic [`EXEC_XLEN-1:0]      value
);

    logic raddr_live;
    logic hit1;
    logic hit2;

    assign raddr_live = (raddr != '0);  // r0 reads as zero, never forwarded

    assign hit1 = fwd1.we && (fwd1.dest == raddr) && raddr_live;
    assign hit2 = fwd2.we && (fwd2.dest == raddr) && raddr_live;

    // nearest stage wins
    always_comb begin
        if (hit1) begin
            value = fwd1.data;
        end else if (hit2) begin
            value = fwd2.data;
        end else begin
            value = reg_value;
        end
    end

endmodule

`default_nettype wire

// File: source/exec_pkg.sv
`default_nettype none
`include "exec_cfg.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_nor, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge,
        br_bltu, br_bgeu, br_jump, br_jump_reg
    } br_kind_e;

    typedef enum logic [1:0] {
        mem_byte, mem_half, mem_word
    } mem_size_e;

    typedef struct packed {
        alu_op_e                alu_op;
        br_kind_e               br_kind;
        logic                   pred_taken;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_4;
        logic                   gr_we;
        logic [`EXEC_RAW-1:0]   dest;
        logic                   mem_we;
        logic                   mem_rd;   // load, result comes from the cache
        mem_size_e              mem_size;
        logic                   use_mul;
        logic                   mul_high;
        logic                   mul_unsigned;
        logic [`EXEC_XLEN-1:0]  imm;
        logic [`EXEC_RAW-1:0]   raddr1;
        logic [`EXEC_RAW-1:0]   raddr2;
        logic [`EXEC_XLEN-1:0]  rj_value;
        logic [`EXEC_XLEN-1:0]  rkd_value;
        logic [`EXEC_XLEN-1:0]  pc;
    } dec_bus_t;

    typedef struct packed {
        logic                   we;
        logic [`EXEC_RAW-1:0]   dest;
        logic [`EXEC_XLEN-1:0]  data;
    } fwd_t;

    typedef struct packed {
        logic                   gr_we;
        logic [`EXEC_RAW-1:0]   dest;
        logic [`EXEC_XLEN-1:0]  result;
        logic [`EXEC_XLEN-1:0]  pc;
    } wb_bus_t;

    typedef struct packed {
        logic                   flush;
        logic [`EXEC_XLEN-1:0]  target;
    } redirect_t;

    typedef struct packed {
        logic                    we;
        logic                    rd;
        logic [`EXEC_LANES-1:0]  be;
        logic [`EXEC_XLEN-1:0]   addr;
        logic [`EXEC_XLEN-1:0]   wdata;
    } dmem_req_t;

    typedef struct packed {
        logic                   ready;
        logic                   rvalid;
        logic [`EXEC_XLEN-1:0]  rdata;
    } dmem_resp_t;

endpackage

`default_nettype wire

// File: source/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width, fixed by the instruction set
`define EXEC_XLEN 32

// register file address width
`define EXEC_RAW 5

// byte lanes per data word
`define EXEC_LANES (`EXEC_XLEN / 8)

// sequential pc step
`define EXEC_PC_STEP 4

`endif
